/* mips_cfg.svh */
// shared configuration macros for the multicycle MIPS core
// include this wherever widths, the register count or the start address are needed

`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// first instruction is fetched from here after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// data path and address width
`define MIPS_XLEN 32

// architectural register count
`define MIPS_NREGS 32

// width of a register specifier in the instruction word
`define MIPS_REG_AW 5

`endif

/* mips_pkg.sv */
// types shared by the MIPS core blocks
// refer to them by scoped name, e.g. mips_pkg::state_t

`default_nettype none

package mips_pkg;

    // multicycle controller states
    typedef enum logic [2:0] {
        STATE_FETCH     = 3'd0,
        STATE_EXECUTE   = 3'd1,
        STATE_MEMORY    = 3'd2,
        STATE_WRITEBACK = 3'd3,
        STATE_HALT      = 3'd4
    } state_t;

    // primary opcodes, bits 31:26 of the instruction
    typedef enum logic [5:0] {
        OPCODE_RTYPE = 6'b00_0000,
        OPCODE_J     = 6'b00_0010,
        OPCODE_JAL   = 6'b00_0011,
        OPCODE_ADDIU = 6'b00_1001,
        OPCODE_LW    = 6'b10_0011,
        OPCODE_SW    = 6'b10_1011
    } opcode_t;

    // function field of R-type instructions, bits 5:0
    typedef enum logic [5:0] {
        FUNCT_JR   = 6'b00_1000,
        FUNCT_ADDU = 6'b10_0001
    } funct_t;

    typedef enum logic {
        ALU_ADD    = 1'b0,   // modulo 2^32 sum, no overflow trap
        ALU_PASS_B = 1'b1    // used for the JAL link value
    } alu_op_t;

endpackage

`default_nettype wire

/* mips_bus_unit.sv */
// Avalon-MM master side of the core
// turns the controller's held requests into bus strobes and reports acceptance;
// read data is captured so it stays valid after the slave moves on

`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_bus_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req_read,
    input  logic                  req_write,
    input  logic [`MIPS_XLEN-1:0] req_addr,
    input  logic [`MIPS_XLEN-1:0] req_wdata,
    input  logic                  waitrequest,
    input  logic [`MIPS_XLEN-1:0] readdata,
    output logic [`MIPS_XLEN-1:0] address,
    output logic                  read,
    output logic                  write,
    output logic [`MIPS_XLEN-1:0] writedata,
    output logic [3:0]            byteenable,
    output logic                  done,
    output logic [`MIPS_XLEN-1:0] rdata
);

    logic                  read_pending;   // readdata is on the bus this cycle
    logic [`MIPS_XLEN-1:0] rdata_q;
    logic                  any_req;

    assign any_req = (req_read || req_write) && !reset;

    // the controller already holds its request steady until acceptance, so the
    // payload goes straight onto the bus and the strobes stay low only in reset
    assign read      = req_read && !reset;
    assign write     = req_write && !reset;
    assign address   = req_addr;
    assign writedata = req_wdata;

    assign byteenable = any_req ? 4'b1111 : 4'b0000;   // word accesses only

    assign done = any_req && !waitrequest;   // one pulse in the accepting cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            read_pending <= 1'b0;
        end else begin
            read_pending <= req_read && !waitrequest;
        end
    end

    always_ff @(posedge clk) begin
        if (read_pending) begin
            rdata_q <= readdata;
        end
    end

    // fixed latency of one, so the word is taken live in the cycle after
    // acceptance and from the holding register later on
    assign rdata = read_pending ? readdata : rdata_q;

endmodule

`default_nettype wire

/* mips_control.sv */
// multicycle controller: FETCH, EXECUTE, MEMORY, WRITEBACK and HALT
// owns the PC and instruction register, decodes the instruction and
// steers the register file, ALU and bus requests

`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    bus_done,
    input  logic [`MIPS_XLEN-1:0]   bus_rdata,
    output logic                    bus_req_read,
    output logic                    bus_req_write,
    output logic [`MIPS_XLEN-1:0]   bus_addr,
    output logic [`MIPS_XLEN-1:0]   bus_wdata,
    output logic [`MIPS_REG_AW-1:0] rs_addr,
    output logic [`MIPS_REG_AW-1:0] rt_addr,
    output logic [`MIPS_REG_AW-1:0] wr_addr,
    output logic                    wr_en,
    output logic [`MIPS_XLEN-1:0]   wr_data,
    input  logic [`MIPS_XLEN-1:0]   rs_val,
    input  logic [`MIPS_XLEN-1:0]   rt_val,
    output mips_pkg::alu_op_t       alu_op,
    output logic [`MIPS_XLEN-1:0]   alu_b,
    input  logic [`MIPS_XLEN-1:0]   alu_result,
    output logic                    active
);

    localparam logic [`MIPS_REG_AW-1:0] link_reg = `MIPS_REG_AW'(31);

    mips_pkg::state_t      state;
    mips_pkg::opcode_t     opcode;
    mips_pkg::funct_t      funct;
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] ir;
    logic [`MIPS_XLEN-1:0] instr;
    logic [`MIPS_XLEN-1:0] next_pc;
    logic [`MIPS_XLEN-1:0] imm_ext;
    logic [`MIPS_REG_AW-1:0] rd_addr;
    logic [25:0]           target;
    logic                  is_addu;
    logic                  is_jr;
    logic                  is_jump;
    logic                  is_mem;

    // the fetched word is decoded straight from the bus during EXECUTE
    assign instr = (state == mips_pkg::STATE_EXECUTE) ? bus_rdata : ir;

    assign opcode  = mips_pkg::opcode_t'(instr[31:26]);
    assign funct   = mips_pkg::funct_t'(instr[5:0]);
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign rd_addr = instr[15:11];
    assign target  = instr[25:0];
    assign imm_ext = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};

    assign is_addu = (opcode == mips_pkg::OPCODE_RTYPE) && (funct == mips_pkg::FUNCT_ADDU);
    assign is_jr   = (opcode == mips_pkg::OPCODE_RTYPE) && (funct == mips_pkg::FUNCT_JR);
    assign is_jump = (opcode == mips_pkg::OPCODE_J) || (opcode == mips_pkg::OPCODE_JAL);
    assign is_mem  = (opcode == mips_pkg::OPCODE_LW) || (opcode == mips_pkg::OPCODE_SW);

    assign active = (state != mips_pkg::STATE_HALT);

    always_comb begin
        alu_op = mips_pkg::ALU_ADD;   // rs plus immediate covers ADDIU, LW and SW
        alu_b  = imm_ext;
        if (is_addu) begin
            alu_b = rt_val;
        end else if (opcode == mips_pkg::OPCODE_JAL) begin
            // pc already points past the JAL, which is the link address
            alu_op = mips_pkg::ALU_PASS_B;
            alu_b  = pc;
        end
    end

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = rd_addr;
        wr_data = alu_result;
        if (state == mips_pkg::STATE_EXECUTE) begin
            if (is_addu) begin
                wr_en = 1'b1;
            end else if (opcode == mips_pkg::OPCODE_ADDIU) begin
                wr_en   = 1'b1;
                wr_addr = rt_addr;
            end else if (opcode == mips_pkg::OPCODE_JAL) begin
                wr_en   = 1'b1;
                wr_addr = link_reg;
            end
        end else if (state == mips_pkg::STATE_WRITEBACK) begin
            wr_en   = 1'b1;   // load result lands in rt
            wr_addr = rt_addr;
            wr_data = bus_rdata;
        end
    end

    // the data address stays valid through MEMORY because ir and the
    // source register do not change until the access completes
    always_comb begin
        bus_req_read  = (state == mips_pkg::STATE_FETCH) ||
                        (state == mips_pkg::STATE_MEMORY && opcode == mips_pkg::OPCODE_LW);
        bus_req_write = (state == mips_pkg::STATE_MEMORY) && (opcode == mips_pkg::OPCODE_SW);
        bus_addr      = (state == mips_pkg::STATE_FETCH) ? pc : alu_result;
        bus_wdata     = rt_val;
    end

    always_comb begin
        next_pc = pc;
        if (is_jump) begin
            next_pc = {pc[`MIPS_XLEN-1:28], target, 2'b00};
        end else if (is_jr) begin
            next_pc = rs_val;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_pkg::STATE_FETCH;
            pc    <= `MIPS_RESET_VECTOR;
            ir    <= '0;   // decodes as a harmless shift by zero
        end else begin
            case (state)
                mips_pkg::STATE_FETCH: begin
                    if (bus_done) begin
                        pc    <= pc + `MIPS_XLEN'd4;
                        state <= mips_pkg::STATE_EXECUTE;
                    end
                end
                mips_pkg::STATE_EXECUTE: begin
                    ir <= bus_rdata;
                    pc <= next_pc;
                    if (is_mem) begin
                        state <= mips_pkg::STATE_MEMORY;
                    end else if (next_pc == '0) begin
                        state <= mips_pkg::STATE_HALT;   // program returned to address zero
                    end else begin
                        state <= mips_pkg::STATE_FETCH;
                    end
                end
                mips_pkg::STATE_MEMORY: begin
                    if (bus_done) begin
                        state <= (opcode == mips_pkg::OPCODE_LW) ? mips_pkg::STATE_WRITEBACK
                                                                 : mips_pkg::STATE_FETCH;
                    end
                end
                mips_pkg::STATE_WRITEBACK: state <= mips_pkg::STATE_FETCH;
                default: state <= mips_pkg::STATE_HALT;   // stays here until reset
            endcase
        end
    end

endmodule

`default_nettype wire

/* mips_alu.sv */
// integer ALU for the core
// a is always rs; the controller picks b and the operation

`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_alu (
    input  mips_pkg::alu_op_t     op,
    input  logic [`MIPS_XLEN-1:0] a,
    input  logic [`MIPS_XLEN-1:0] b,
    output logic [`MIPS_XLEN-1:0] result
);

    logic [`MIPS_XLEN-1:0] sum;

    // unsigned wrap-around, ADDU and ADDIU never trap
    assign sum = a + b;

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: begin
                result = sum;
            end
            mips_pkg::ALU_PASS_B: begin
                result = b;   // link value for JAL
            end
            default: begin
                result = sum;
            end
        endcase
    end

endmodule

`default_nettype wire

/* mips_reg_file.sv */
// general purpose register file with two read ports and one write port
// register 0 reads as zero and register 2 is exposed as register_v0

`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`MIPS_REG_AW-1:0] rs_addr,
    input  logic [`MIPS_REG_AW-1:0] rt_addr,
    input  logic [`MIPS_REG_AW-1:0] wr_addr,
    input  logic                    wr_en,
    input  logic [`MIPS_XLEN-1:0]   wr_data,
    output logic [`MIPS_XLEN-1:0]   rs_val,
    output logic [`MIPS_XLEN-1:0]   rt_val,
    output logic [`MIPS_XLEN-1:0]   register_v0
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;   // writes to $zero are dropped
        end
    end

    assign rs_val = regs[rs_addr];   // asynchronous read, new value visible next cycle
    assign rt_val = regs[rt_addr];

    assign register_v0 = regs[2];

endmodule

`default_nettype wire

/* mips_cpu_bus.sv */
// top level of the multicycle MIPS core with an Avalon-MM master port
// active drops once the program jumps to address zero

`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_cpu_bus (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  active,
    output logic [`MIPS_XLEN-1:0] register_v0,

    output logic [`MIPS_XLEN-1:0] address,
    output logic                  write,
    output logic                  read,
    input  logic                  waitrequest,
    output logic [`MIPS_XLEN-1:0] writedata,
    output logic [3:0]            byteenable,
    input  logic [`MIPS_XLEN-1:0] readdata
);

    logic                    bus_req_read;
    logic                    bus_req_write;
    logic [`MIPS_XLEN-1:0]   bus_addr;
    logic [`MIPS_XLEN-1:0]   bus_wdata;
    logic                    bus_done;
    logic [`MIPS_XLEN-1:0]   bus_rdata;
    logic [`MIPS_REG_AW-1:0] rs_addr;
    logic [`MIPS_REG_AW-1:0] rt_addr;
    logic [`MIPS_REG_AW-1:0] wr_addr;
    logic                    wr_en;
    logic [`MIPS_XLEN-1:0]   wr_data;
    logic [`MIPS_XLEN-1:0]   rs_val;
    logic [`MIPS_XLEN-1:0]   rt_val;
    mips_pkg::alu_op_t       alu_op;
    logic [`MIPS_XLEN-1:0]   alu_b;
    logic [`MIPS_XLEN-1:0]   alu_result;

    mips_bus_unit bus_unit0 (
        .clk        (clk),
        .reset      (reset),
        .req_read   (bus_req_read),
        .req_write  (bus_req_write),
        .req_addr   (bus_addr),
        .req_wdata  (bus_wdata),
        .waitrequest(waitrequest),
        .readdata   (readdata),
        .address    (address),
        .read       (read),
        .write      (write),
        .writedata  (writedata),
        .byteenable (byteenable),
        .done       (bus_done),
        .rdata      (bus_rdata)
    );

    mips_control control0 (
        .clk          (clk),
        .reset        (reset),
        .bus_done     (bus_done),
        .bus_rdata    (bus_rdata),
        .bus_req_read (bus_req_read),
        .bus_req_write(bus_req_write),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .rs_addr      (rs_addr),
        .rt_addr      (rt_addr),
        .wr_addr      (wr_addr),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .alu_op       (alu_op),
        .alu_b        (alu_b),
        .alu_result   (alu_result),
        .active       (active)
    );

    // operand a is always the rs register
    mips_alu alu0 (
        .op    (alu_op),
        .a     (rs_val),
        .b     (alu_b),
        .result(alu_result)
    );

    mips_reg_file reg_file0 (
        .clk        (clk),
        .reset      (reset),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .wr_addr    (wr_addr),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .register_v0(register_v0)
    );

endmodule

`default_nettype wire

/* mips_cpu_bus_asserts.sv */
// concurrent checks on the Avalon master port of the core
// bound into every mips_cpu_bus instance; a violation is raised through $error

`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_cpu_bus_asserts (
    input logic                  clk,
    input logic                  reset,
    input logic                  read,
    input logic                  write,
    input logic                  waitrequest,
    input logic [`MIPS_XLEN-1:0] address,
    input logic [`MIPS_XLEN-1:0] writedata,
    input logic [3:0]            byteenable
);

    // one shared port, so a cycle carries at most one access
    no_read_and_write: assert property (
        @(posedge clk) disable iff (reset) !(read && write)
    ) else $error("read and write are high in the same cycle");

    held_access_stable: assert property (
        @(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(read) && $stable(write) && $stable(address) &&
            (!write || $stable(writedata))   // write data only matters for a store
    ) else $error("access changed while waitrequest was high");

    byteenable_full: assert property (
        @(posedge clk) disable iff (reset) (read || write) |-> byteenable == 4'b1111
    ) else $error("byteenable is not all ones during an access");

endmodule

bind mips_cpu_bus mips_cpu_bus_asserts asserts0 (
    .clk        (clk),
    .reset      (reset),
    .read       (read),
    .write      (write),
    .waitrequest(waitrequest),
    .address    (address),
    .writedata  (writedata),
    .byteenable (byteenable)
);

`default_nettype wire

/* mips_cpu_bus_tb.sv */
// testbench for mips_cpu_bus that runs three small programs from a word memory model,
// each once without and once with random waitrequest stalls, and compares the
// bus writes, register_v0 and the fetch count against an instruction-set model

`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_cpu_bus_tb;

    localparam logic [31:0] data_base  = 32'h0000_1000;
    localparam int          prog_words = 64;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic [31:0] writedata;
    logic        read;
    logic        write;
    logic [3:0]  byteenable;

    logic [31:0] prog_mem [prog_words];
    logic [31:0] data_mem [prog_words];
    logic [31:0] exp_addr_q[$];
    logic [31:0] exp_data_q[$];
    logic [31:0] obs_addr_q[$];
    logic [31:0] obs_data_q[$];
    logic [31:0] exp_v0;
    logic [31:0] rd_addr_q;
    int          value_errors = 0;
    int          other_errors = 0;
    int          fetch_count = 0;
    int          budget_cycles = 0;
    bit          model_on = 1'b0;   // memory answers only outside reset
    bit          stall_en = 1'b0;
    bit          first_read = 1'b0;
    bit          rd_pending = 1'b0;

    mips_cpu_bus dut0 (
        .clk        (clk),
        .reset      (reset),
        .active     (active),
        .register_v0(register_v0),
        .address    (address),
        .write      (write),
        .read       (read),
        .waitrequest(waitrequest),
        .writedata  (writedata),
        .byteenable (byteenable),
        .readdata   (readdata)
    );

    always #4 clk = ~clk;

    function automatic bit in_prog(input logic [31:0] addr);
        return addr >= `MIPS_RESET_VECTOR && addr < `MIPS_RESET_VECTOR + 32'd256;
    endfunction

    function automatic bit in_data(input logic [31:0] addr);
        return addr >= data_base && addr < data_base + 32'd256;
    endfunction

    // preloaded data differs at every address so a wrong load is visible
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] funct);
        return {6'b00_0000, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_type(input logic [5:0] op, input int idx);
        logic [31:0] dest;
        dest = `MIPS_RESET_VECTOR + 32'(idx * 4);
        return {op, dest[27:2]};
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        if (in_prog(addr)) return prog_mem[addr[7:2]];
        if (in_data(addr)) return data_mem[addr[7:2]];
        $display("read from an unmapped address %h", addr);
        other_errors++;
        return '0;
    endfunction

    // instruction-set model that fills the expected write list and register_v0
    function automatic int run_reference();
        logic [31:0] r [32];
        logic [31:0] dm [prog_words];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] ea;
        int          count;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        for (int i = 0; i < prog_words; i++) begin
            dm[i] = fill_word(data_base + 32'(i * 4));
        end
        exp_addr_q.delete();
        exp_data_q.delete();
        pc = `MIPS_RESET_VECTOR;
        count = 0;
        while (pc != 0 && count < 1000 && in_prog(pc)) begin
            ins = prog_mem[pc[7:2]];
            pc = pc + 4;   // there is no delay slot so a jump takes effect right away
            count++;
            ea = r[ins[25:21]] + {{16{ins[15]}}, ins[15:0]};
            case (ins[31:26])
                mips_pkg::OPCODE_RTYPE: begin
                    if (ins[5:0] == mips_pkg::FUNCT_ADDU) begin
                        r[ins[15:11]] = r[ins[25:21]] + r[ins[20:16]];
                    end else if (ins[5:0] == mips_pkg::FUNCT_JR) begin
                        pc = r[ins[25:21]];
                    end
                end
                mips_pkg::OPCODE_ADDIU: r[ins[20:16]] = ea;
                mips_pkg::OPCODE_J: pc = {pc[31:28], ins[25:0], 2'b00};
                mips_pkg::OPCODE_JAL: begin
                    r[31] = pc;
                    pc = {pc[31:28], ins[25:0], 2'b00};
                end
                mips_pkg::OPCODE_LW: r[ins[20:16]] = dm[ea[7:2]];
                mips_pkg::OPCODE_SW: begin
                    dm[ea[7:2]] = r[ins[20:16]];
                    exp_addr_q.push_back(ea);
                    exp_data_q.push_back(r[ins[20:16]]);
                end
                default: ;   // anything else only moves the PC on
            endcase
            r[0] = '0;
        end
        exp_v0 = r[2];
        return count;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic load_program(input int prog);
        for (int i = 0; i < prog_words; i++) begin
            prog_mem[i] = '0;   // an all-zero word decodes as a no-op
        end
        case (prog)
            0: begin   // arithmetic with wrap-around, a no-op opcode and a write to $zero
                prog_mem[0] = i_type(mips_pkg::OPCODE_ADDIU, 0, 1, 16'h7fff);
                prog_mem[1] = i_type(mips_pkg::OPCODE_ADDIU, 0, 3, 16'hffff);
                prog_mem[2] = r_type(1, 3, 2, mips_pkg::FUNCT_ADDU);
                prog_mem[3] = i_type(6'h0f, 0, 2, 16'hffff);
                prog_mem[4] = i_type(mips_pkg::OPCODE_ADDIU, 0, 5, 16'h8000);
                prog_mem[5] = r_type(2, 5, 2, mips_pkg::FUNCT_ADDU);
                prog_mem[6] = r_type(2, 1, 2, mips_pkg::FUNCT_ADDU);
                prog_mem[7] = i_type(mips_pkg::OPCODE_ADDIU, 0, 0, 16'h0005);
                prog_mem[8] = r_type(2, 0, 2, mips_pkg::FUNCT_ADDU);
                prog_mem[9] = r_type(0, 0, 0, mips_pkg::FUNCT_JR);
            end
            1: begin   // store, load back, negative offsets and preloaded data
                prog_mem[0]  = i_type(mips_pkg::OPCODE_ADDIU, 0, 4, 16'h1000);
                prog_mem[1]  = i_type(mips_pkg::OPCODE_ADDIU, 0, 5, 16'hedcb);
                prog_mem[2]  = i_type(mips_pkg::OPCODE_SW, 4, 5, 16'h0008);
                prog_mem[3]  = i_type(mips_pkg::OPCODE_LW, 4, 6, 16'h0008);
                prog_mem[4]  = i_type(mips_pkg::OPCODE_SW, 4, 6, 16'h000c);
                prog_mem[5]  = i_type(mips_pkg::OPCODE_LW, 4, 7, 16'h0020);
                prog_mem[6]  = r_type(6, 7, 2, mips_pkg::FUNCT_ADDU);
                prog_mem[7]  = i_type(mips_pkg::OPCODE_ADDIU, 4, 8, 16'h0010);
                prog_mem[8]  = i_type(mips_pkg::OPCODE_SW, 8, 2, 16'hfff8);
                prog_mem[9]  = i_type(mips_pkg::OPCODE_LW, 4, 2, 16'h0008);
                prog_mem[10] = r_type(0, 0, 0, mips_pkg::FUNCT_JR);
            end
            default: begin   // call and return, with a skipped word after the jump
                prog_mem[0]  = i_type(mips_pkg::OPCODE_ADDIU, 0, 4, 16'h1000);
                prog_mem[1]  = i_type(mips_pkg::OPCODE_ADDIU, 0, 2, 16'h0001);
                prog_mem[2]  = j_type(mips_pkg::OPCODE_JAL, 6);
                prog_mem[3]  = i_type(mips_pkg::OPCODE_SW, 4, 2, 16'h0000);
                prog_mem[4]  = j_type(mips_pkg::OPCODE_J, 9);
                prog_mem[5]  = i_type(mips_pkg::OPCODE_ADDIU, 0, 2, 16'h7777);
                prog_mem[6]  = i_type(mips_pkg::OPCODE_ADDIU, 2, 2, 16'h0005);
                prog_mem[7]  = i_type(mips_pkg::OPCODE_SW, 4, 31, 16'h0004);
                prog_mem[8]  = r_type(31, 0, 0, mips_pkg::FUNCT_JR);
                prog_mem[9]  = i_type(mips_pkg::OPCODE_SW, 4, 2, 16'h0008);
                prog_mem[10] = r_type(0, 0, 0, mips_pkg::FUNCT_JR);
            end
        endcase
    endtask

    // memory model with readdata one cycle after an accepted read
    always @(negedge clk) begin
        readdata = rd_pending ? mem_read(rd_addr_q) : 'x;
        rd_pending = 1'b0;
        if (!model_on) begin
            waitrequest = 1'b1;
        end else begin
            waitrequest = stall_en ? ($urandom % 3 == 0) : 1'b0;
            if (read || write) begin
                check_word("byteenable", 32'(byteenable), 32'h0000_000f);
            end
            if (!waitrequest && read) begin
                rd_pending = 1'b1;
                rd_addr_q = address;
                if (first_read) check_word("address", address, `MIPS_RESET_VECTOR);
                first_read = 1'b0;
                if (in_prog(address)) fetch_count++;
            end
            if (!waitrequest && write) begin
                if (in_data(address)) begin
                    data_mem[address[7:2]] = writedata;
                end else begin
                    $display("bus write to an unmapped address %h", address);
                    other_errors++;
                end
                obs_addr_q.push_back(address);
                obs_data_q.push_back(writedata);
            end
        end
    end

    // compare process for accepted bus writes
    always @(posedge clk) begin
        while (obs_addr_q.size() > 0) begin
            if (exp_addr_q.size() == 0) begin
                $display("unexpected bus write to address %h", obs_addr_q[0]);
                other_errors++;
            end else begin
                check_word("address", obs_addr_q[0], exp_addr_q.pop_front());
                check_word("writedata", obs_data_q[0], exp_data_q.pop_front());
            end
            void'(obs_addr_q.pop_front());
            void'(obs_data_q.pop_front());
        end
    end

    task automatic run_program(input int prog, input bit stall);
        int exp_count;
        load_program(prog);
        exp_count = run_reference();
        @(posedge clk);
        model_on = 1'b0;
        for (int i = 0; i < prog_words; i++) begin
            data_mem[i] = fill_word(data_base + 32'(i * 4));
        end
        @(negedge clk);
        reset = 1'b1;
        repeat (3) @(negedge clk);
        check_flag("read", read, 1'b0);
        check_flag("write", write, 1'b0);
        check_flag("active", active, 1'b1);
        check_word("byteenable", 32'(byteenable), 32'h0);
        reset = 1'b0;
        @(posedge clk);
        stall_en = stall;
        fetch_count = 0;
        first_read = 1'b1;
        model_on = 1'b1;
        while (active) @(negedge clk);
        repeat (4) begin   // halted core keeps the bus quiet
            @(negedge clk);
            check_flag("read", read, 1'b0);
            check_flag("write", write, 1'b0);
            check_word("byteenable", 32'(byteenable), 32'h0);
        end
        check_flag("active", active, 1'b0);
        check_word("register_v0", register_v0, exp_v0);
        check_word("fetch_count", 32'(fetch_count), 32'(exp_count));
        if (exp_addr_q.size() != 0) begin
            $display("program %0d ended with %0d bus writes missing", prog, exp_addr_q.size());
            other_errors++;
        end
    endtask

    initial begin
        int seed;
        int total;
        clk = 1'b0;
        reset = 1'b1;
        waitrequest = 1'b1;
        readdata = '0;
        seed = 32'h3ce5539e;
        void'($urandom(seed));
        total = 0;
        for (int p = 0; p < 3; p++) begin
            load_program(p);
            total += run_reference();
        end
        budget_cycles = 2 * 10 * total + 200;   // every program runs twice
        for (int p = 0; p < 3; p++) begin
            run_program(p, 1'b0);
            run_program(p, 1'b1);
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("timeout: the programs did not finish within %0d cycles", budget_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
mips_pkg.sv
mips_bus_unit.sv
mips_control.sv
mips_alu.sv
mips_reg_file.sv
mips_cpu_bus.sv
mips_cpu_bus_asserts.sv
mips_cpu_bus_tb.sv

/* Bender.yml */
package:
  name: mips_cpu_bus

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mips_pkg.sv
      - mips_bus_unit.sv
      - mips_control.sv
      - mips_alu.sv
      - mips_reg_file.sv
      - mips_cpu_bus.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - mips_cpu_bus_asserts.sv
      - mips_cpu_bus_tb.sv
